//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f pp_link.f \
		--top-module pp_link_tb -Mdir obj_dir
	./obj_dir/Vpp_link_tb | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

//--- common/pp_link_pkg.sv
package pp_link_pkg;

    // ----------------------------------------------------------------------
    // widths and counts
    // ----------------------------------------------------------------------
    localparam int DATA_W        = 32;            // one message word
    localparam int N_CH          = 2;             // 0 er / 1 pa
    localparam int CH_ID_W       = 4;             // channel field in header
    localparam int SEQ_W         = 8;             // per channel sequence
    localparam int LEN_W         = 11;            // payload length in words
    localparam int FIFO_DEPTH    = 16;            // words per channel queue
    localparam int MAX_MSG_WORDS = FIFO_DEPTH;    // whole msg must fit the queue
    localparam int LEN_Q_DEPTH   = 4;             // completed msgs per channel

    // derived
    localparam int CH_SEL_W   = (N_CH > 1) ? $clog2(N_CH) : 1;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int LQ_PTR_W   = $clog2(LEN_Q_DEPTH);
    localparam int RSVD_W     = DATA_W - CH_ID_W - SEQ_W - LEN_W;   // 9 spare bits

    // ----------------------------------------------------------------------
    // stream beats
    // ----------------------------------------------------------------------

    // engine side word stream into a channel queue
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
        logic              last;   // final word of the message
    } chan_beat_t;

    // network side message stream
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
        logic              last;   // final payload beat
    } msg_beat_t;

    // ----------------------------------------------------------------------
    // header word
    // ----------------------------------------------------------------------

    // first beat of every message
    typedef struct packed {
        logic [CH_ID_W-1:0] ch_id;   // destination channel
        logic [SEQ_W-1:0]   seq;     // per channel counter
        logic [LEN_W-1:0]   len;     // payload words after the header
        logic [RSVD_W-1:0]  rsvd;    // sent as zero
    } msg_hdr_t;

    // header beat decodes as hdr and payload beats as raw
    typedef union packed {
        logic [DATA_W-1:0] raw;
        msg_hdr_t          hdr;
    } msg_word_u;

endpackage

//--- dv/pp_link_checker.sv
module pp_link_checker (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  pp_link_pkg::chan_beat_t [pp_link_pkg::N_CH-1:0]   ch_in,
    input  logic [pp_link_pkg::N_CH-1:0]                      ch_ready,
    input  pp_link_pkg::msg_beat_t                            tx_msg,
    input  logic                                              tx_ready,
    input  pp_link_pkg::chan_beat_t [pp_link_pkg::N_CH-1:0]   ch_out,
    input  logic                                              msg_err,
    input  logic                                              seq_err
);
    import pp_link_pkg::*;

    // expected tx side built from words the engines handed over
    logic [DATA_W-1:0] tx_words [N_CH][$];
    int                exp_len_q [N_CH][$];
    int                open_len [N_CH];          // words of the message being queued
    logic [SEQ_W-1:0]  exp_seq [N_CH];
    // expected rx side loaded from the data file
    logic [DATA_W-1:0] out_data_q [N_CH][$];
    logic              out_last_q [N_CH][$];

    int        err_cnt = 0;
    int        chk_cnt = 0;
    int        msg_err_cnt = 0;              // pulses since last pulse check
    int        seq_err_cnt = 0;
    bit        in_tx = 0;                     // header seen and payload open
    int        tx_ch = 0;
    int        tx_rem = 0;
    msg_beat_t held;                          // beat stalled by tx_ready
    bit        held_vld = 0;

    initial begin
        for (int i = 0; i < N_CH; i++) begin
            open_len[i] = 0;
            exp_seq[i]  = '0;
        end
    end

    task automatic check_val(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic fail_note(input string what);
        err_cnt++;
        $display("checker: %s at %0t", what, $time);
    endtask

    // ----------------------------------------------------------------------
    // tx message framing rules
    // ----------------------------------------------------------------------
    task automatic check_tx_beat(input msg_beat_t b);
        msg_hdr_t hdr;
        int       exp_len;
        if (!in_tx) begin
            hdr = msg_hdr_t'(b.data);           // first beat is the header
            if (int'(hdr.ch_id) >= N_CH) begin
                fail_note($sformatf("tx header names channel %0d", hdr.ch_id));
            end else begin
                tx_ch = int'(hdr.ch_id);
                check_val("tx_msg.seq", 32'(hdr.seq), 32'(exp_seq[tx_ch]));
                exp_seq[tx_ch] = exp_seq[tx_ch] + 1'b1;   // wraps like the field
                if (exp_len_q[tx_ch].size() == 0) begin
                    fail_note($sformatf("tx header for channel %0d with nothing queued", tx_ch));
                    exp_len = int'(hdr.len);   // follow the header to stay framed
                end else begin
                    exp_len = exp_len_q[tx_ch].pop_front();
                    check_val("tx_msg.len", 32'(hdr.len), 32'(exp_len));
                end
                check_val("tx_msg.rsvd", 32'(hdr.rsvd), 32'h0);
                check_val("tx_msg.last", 32'(b.last), 32'h0);   // header never closes
                tx_rem = exp_len;
                in_tx  = (tx_rem != 0);
            end
        end else begin
            if (tx_words[tx_ch].size() == 0)
                fail_note($sformatf("extra tx payload word on channel %0d", tx_ch));
            else
                check_val("tx_msg.data", b.data, tx_words[tx_ch].pop_front());
            check_val("tx_msg.last", 32'(b.last), 32'(tx_rem == 1));
            tx_rem--;
            if (b.last || tx_rem == 0)
                in_tx = 0;
        end
    endtask

    // ----------------------------------------------------------------------
    // monitor sampled mid cycle
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst_n) begin
            in_tx    = 0;
            held_vld = 0;
        end else begin
            for (int i = 0; i < N_CH; i++) begin
                if (ch_in[i].valid && ch_ready[i]) begin
                    tx_words[i].push_back(ch_in[i].data);
                    open_len[i]++;
                    if (ch_in[i].last) begin   // message complete
                        exp_len_q[i].push_back(open_len[i]);
                        open_len[i] = 0;
                    end
                end
            end
            if (held_vld && (tx_msg !== held))
                fail_note($sformatf("tx_msg changed from %h to %h while stalled",
                                    held, tx_msg));
            held_vld = tx_msg.valid && !tx_ready;
            held     = tx_msg;
            if (tx_msg.valid && tx_ready)
                check_tx_beat(tx_msg);
            for (int i = 0; i < N_CH; i++) begin
                if (ch_out[i].valid) begin
                    if (out_data_q[i].size() == 0) begin
                        fail_note($sformatf("unexpected ch_out[%0d] word %h", i,
                                            ch_out[i].data));
                    end else begin
                        check_val($sformatf("ch_out[%0d].data", i), ch_out[i].data,
                                  out_data_q[i].pop_front());
                        check_val($sformatf("ch_out[%0d].last", i), 32'(ch_out[i].last),
                                  32'(out_last_q[i].pop_front()));
                    end
                end
            end
            if (msg_err)
                msg_err_cnt++;
            if (seq_err)
                seq_err_cnt++;
        end
    end

    // expected rx word for one channel
    task automatic expect_out(input int ch, input logic [DATA_W-1:0] data, input logic last);
        out_data_q[ch].push_back(data);
        out_last_q[ch].push_back(last);
    endtask

    // pulses seen since the previous call
    task automatic check_pulses(input int exp_msg, input int exp_seq_err);
        check_val("msg_err count", 32'(msg_err_cnt), 32'(exp_msg));
        check_val("seq_err count", 32'(seq_err_cnt), 32'(exp_seq_err));
        msg_err_cnt = 0;
        seq_err_cnt = 0;
    endtask

    function automatic bit tx_idle();
        bit idle;
        idle = !in_tx;
        for (int i = 0; i < N_CH; i++)
            if (tx_words[i].size() != 0)
                idle = 0;
        return idle;
    endfunction

    // nothing may be left over
    task automatic final_check();
        for (int i = 0; i < N_CH; i++) begin
            if (tx_words[i].size() != 0)
                fail_note($sformatf("%0d words on channel %0d never sent", tx_words[i].size(), i));
            if (out_data_q[i].size() != 0)
                fail_note($sformatf("%0d words missing on ch_out[%0d]", out_data_q[i].size(), i));
            if (open_len[i] != 0)
                fail_note($sformatf("channel %0d message left open", i));
        end
    endtask

endmodule

//--- dv/pp_link_tb.sv
module pp_link_tb;
    import pp_link_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 16;
    localparam string DATA_FILE = "dv/pp_link_testdata.txt";

    logic                   clk;
    logic                   rst_n;
    chan_beat_t [N_CH-1:0]  ch_in;
    logic [N_CH-1:0]        ch_ready;
    msg_beat_t              tx_msg;
    logic                   tx_ready;
    msg_beat_t              rx_msg;
    chan_beat_t [N_CH-1:0]  ch_out;
    logic                   msg_err;
    logic                   seq_err;

    integer seed = 32'hd2c9_6047;
    bit     rnd_ready = 0;        // back pressure section
    bit     limit_set = 0;
    int     limit_cycles = 0;
    int     bad_recs = 0;

    // parsed records
    byte               rec_kind [$];
    logic [DATA_W-1:0] rec_a [$];
    logic [DATA_W-1:0] rec_b [$];
    logic [DATA_W-1:0] rec_c [$];

    pp_link_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .ch_in    (ch_in),
        .ch_ready (ch_ready),
        .tx_msg   (tx_msg),
        .tx_ready (tx_ready),
        .rx_msg   (rx_msg),
        .ch_out   (ch_out),
        .msg_err  (msg_err),
        .seq_err  (seq_err)
    );

    pp_link_checker i_chk (
        .clk      (clk),
        .rst_n    (rst_n),
        .ch_in    (ch_in),
        .ch_ready (ch_ready),
        .tx_msg   (tx_msg),
        .tx_ready (tx_ready),
        .ch_out   (ch_out),
        .msg_err  (msg_err),
        .seq_err  (seq_err)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // tx_ready moves 1 unit after the edge like every other input
    always @(posedge clk) begin
        #1;
        tx_ready = rnd_ready ? 1'($random(seed)) : 1'b1;
    end

    // ----------------------------------------------------------------------
    // data file
    // ----------------------------------------------------------------------
    task automatic read_records(output bit ok);
        int    fd;
        int    beats;
        string line;
        logic [DATA_W-1:0] a, b, c;
        beats = 0;
        fd = $fopen(DATA_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;   // blank or comment
                a = '0;
                b = '0;
                c = '0;
                void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
                rec_kind.push_back(line.getc(0));
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_c.push_back(c);
                if (line.getc(0) == "C")
                    beats += 1 + int'(c[0]);   // last word also costs a header
                else if (line.getc(0) == "R")
                    beats++;
            end
            $fclose(fd);
            limit_cycles = beats * 8 + RST_CYCLES;
            limit_set    = 1;
        end
    endtask

    // ----------------------------------------------------------------------
    // drivers entered and left 1 unit after a rising edge
    // ----------------------------------------------------------------------
    task automatic send_word(input int ch, input logic [DATA_W-1:0] data, input logic last);
        ch_in[ch] = '{valid: 1'b1, data: data, last: last};
        @(negedge clk);
        while (!ch_ready[ch])
            @(negedge clk);   // queue full
        @(posedge clk);
        #1;
        ch_in[ch] = '0;
    endtask

    task automatic send_rx(input logic [DATA_W-1:0] data, input logic last);
        rx_msg = '{valid: 1'b1, data: data, last: last};
        @(posedge clk);
        #1;
        rx_msg = '0;
    endtask

    task automatic wait_tx_drain();
        @(negedge clk);
        while (!i_chk.tx_idle() || tx_msg.valid)
            @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    // pulses land one cycle after the last beat
    task automatic settle_pulses(input int exp_msg, input int exp_seq_err);
        repeat (3) @(posedge clk);
        #1;
        i_chk.check_pulses(exp_msg, exp_seq_err);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        bit ok;
        clk      = 1'b0;
        rst_n    = 1'b0;
        ch_in    = '0;
        rx_msg   = '0;
        tx_ready = 1'b1;
        read_records(ok);
        if (!ok) begin
            $display("could not open %s", DATA_FILE);
            $display("=== FAIL ===");
            $finish;
        end else begin
            repeat (RST_CYCLES) @(posedge clk);
            #1;
            rst_n = 1'b1;
            for (int r = 0; r < rec_kind.size(); r++) begin
                case (rec_kind[r])
                    "T": rnd_ready = rec_a[r][0];
                    "C": send_word(int'(rec_a[r]), rec_b[r], rec_c[r][0]);
                    "W": wait_tx_drain();
                    "R": send_rx(rec_a[r], rec_b[r][0]);
                    "O": i_chk.expect_out(int'(rec_a[r]), rec_b[r], rec_c[r][0]);
                    "E": settle_pulses(int'(rec_a[r]), int'(rec_b[r]));
                    default: begin
                        bad_recs++;
                        $display("unknown record kind %c in data file", rec_kind[r]);
                    end
                endcase
            end
            rnd_ready = 0;
            wait_tx_drain();
            repeat (4) @(posedge clk);
            i_chk.final_check();
            $display("errors %0d, bad records %0d, checks %0d",
                     i_chk.err_cnt, bad_recs, i_chk.chk_cnt);
            if (i_chk.err_cnt == 0 && bad_recs == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

    // limit scales with the beats in the file
    initial begin : watchdog
        wait (limit_set);
        #(limit_cycles * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stuck", limit_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- dv/pp_link_testdata.txt
# C ch data last : engine word into channel queue   W : wait until tx drained
# T mode : tx_ready 0 always high 1 random   R data last : rx beat   O ch data last : expected ch_out   E msg_err seq_err : pulse counts
T 0
C 0 a0000001 0
C 0 a0000002 0
C 0 a0000003 0
C 0 a0000004 0
C 0 a0000005 1
W
C 1 b1000001 0
C 1 b1000002 1
C 0 a1000001 0
C 0 a1000002 1
C 1 b2000001 1
C 0 a2000001 1
C 1 b3000001 0
C 1 b3000002 1
C 0 a3000001 1
W
T 1
C 0 c0000001 0
C 0 c0000002 0
C 0 c0000003 0
C 0 c0000004 1
C 1 d0000001 0
C 1 d0000002 1
C 0 c1000001 0
C 0 c1000002 1
W
T 0
O 1 5a5a0001 0
O 1 5a5a0002 0
O 1 5a5a0003 1
R 10000600 0
R 5a5a0001 0
R 5a5a0002 0
R 5a5a0003 1
E 0 0
R 30000400 0
R deadbee1 0
R deadbee2 1
E 1 0
O 1 66660001 0
O 1 66660002 1
R 10100600 0
R 66660001 0
R 66660002 1
E 1 0
O 0 77770001 1
R 00200200 0
R 77770001 1
E 0 1
O 0 88880001 0
O 0 88880002 1
R 00300400 0
R 88880001 0
R 88880002 1
E 0 0

//--- hw/chan_fifo.sv
module chan_fifo (
    input  logic                             clk,
    input  logic                             rst_n,
    input  pp_link_pkg::chan_beat_t          in_beat,
    output logic                             in_ready,
    input  logic                             pop,
    output pp_link_pkg::chan_beat_t          head_word,
    output logic                             msg_avail,
    output logic [pp_link_pkg::LEN_W-1:0]    head_len
);
    import pp_link_pkg::*;

    // word storage
    logic [DATA_W-1:0]     data_mem [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0] last_mem;
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;

    // completed message lengths
    logic [LEN_W-1:0]      len_mem [LEN_Q_DEPTH];
    logic [LQ_PTR_W-1:0]   lq_wr;
    logic [LQ_PTR_W-1:0]   lq_rd;
    logic [LQ_PTR_W:0]     lq_cnt;
    logic [LEN_W-1:0]      msg_cnt;   // words so far in the open message

    logic push;
    logic retire;

    // stall on full words or when no length slot is left
    assign in_ready = (count != FIFO_DEPTH) && (lq_cnt != LEN_Q_DEPTH);
    assign push     = in_beat.valid && in_ready;
    assign retire   = pop && last_mem[rd_ptr];   // last word leaves with its length

    // ----------------------------------------------------------------------
    // storage writes
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= in_beat.data;
            last_mem[wr_ptr] <= in_beat.last;
        end
        if (push && in_beat.last)
            len_mem[lq_wr] <= msg_cnt + 1'b1;   // includes this word
    end

    // pointers and counts
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            lq_wr   <= '0;
            lq_rd   <= '0;
            lq_cnt  <= '0;
            msg_cnt <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);

            if (push)
                msg_cnt <= in_beat.last ? '0 : msg_cnt + 1'b1;
            if (push && in_beat.last)
                lq_wr <= lq_wr + 1'b1;
            if (retire)
                lq_rd <= lq_rd + 1'b1;
            lq_cnt <= lq_cnt + ((push && in_beat.last) ? 1'b1 : 1'b0) - (retire ? 1'b1 : 1'b0);
        end
    end

    // head view for the packer
    assign head_word.valid = (count != '0);
    assign head_word.data  = data_mem[rd_ptr];
    assign head_word.last  = last_mem[rd_ptr];
    assign msg_avail       = (lq_cnt != '0);   // a full message is waiting
    assign head_len        = len_mem[lq_rd];

    // packer only pops words that are there
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> count != '0);

    // the source must close a message before it overruns the queue
    a_msg_len: assert property (@(posedge clk) disable iff (!rst_n)
        (push && !in_beat.last) |-> msg_cnt < LEN_W'(MAX_MSG_WORDS - 1));

endmodule

//--- hw/pp_link_top.sv
module pp_link_top (
    input  logic                                              clk,
    input  logic                                              rst_n,
    // engine side
    input  pp_link_pkg::chan_beat_t [pp_link_pkg::N_CH-1:0]   ch_in,
    output logic [pp_link_pkg::N_CH-1:0]                      ch_ready,
    // network tx
    output pp_link_pkg::msg_beat_t                            tx_msg,
    input  logic                                              tx_ready,
    // network rx
    input  pp_link_pkg::msg_beat_t                            rx_msg,
    output pp_link_pkg::chan_beat_t [pp_link_pkg::N_CH-1:0]   ch_out,
    output logic                                              msg_err,
    output logic                                              seq_err
);
    import pp_link_pkg::*;

    // queue to packer
    logic [N_CH-1:0]             msg_avail;
    logic [N_CH-1:0][LEN_W-1:0]  head_len;
    chan_beat_t [N_CH-1:0]       head_word;
    logic [N_CH-1:0]             pop;

    // ----------------------------------------------------------------------
    // per channel queues
    // ----------------------------------------------------------------------
    for (genvar g = 0; g < N_CH; g++) begin : g_chan
        chan_fifo i_chan_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_beat   (ch_in[g]),
            .in_ready  (ch_ready[g]),
            .pop       (pop[g]),
            .head_word (head_word[g]),
            .msg_avail (msg_avail[g]),
            .head_len  (head_len[g])
        );
    end

    // ----------------------------------------------------------------------
    // outgoing framer
    // ----------------------------------------------------------------------
    msg_packer i_msg_packer (
        .clk       (clk),
        .rst_n     (rst_n),
        .msg_avail (msg_avail),
        .head_len  (head_len),
        .head_word (head_word),
        .pop       (pop),
        .tx_msg    (tx_msg),
        .tx_ready  (tx_ready)
    );

    // incoming router
    msg_unpacker i_msg_unpacker (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx_msg  (rx_msg),
        .ch_out  (ch_out),
        .msg_err (msg_err),
        .seq_err (seq_err)
    );

endmodule

//--- packer/msg_packer.sv
module msg_packer (
    input  logic                                                    clk,
    input  logic                                                    rst_n,
    input  logic [pp_link_pkg::N_CH-1:0]                            msg_avail,
    input  logic [pp_link_pkg::N_CH-1:0][pp_link_pkg::LEN_W-1:0]    head_len,
    input  pp_link_pkg::chan_beat_t [pp_link_pkg::N_CH-1:0]         head_word,
    output logic [pp_link_pkg::N_CH-1:0]                            pop,
    output pp_link_pkg::msg_beat_t                                  tx_msg,
    input  logic                                                    tx_ready
);
    import pp_link_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,   // looking for a complete message
        ST_HDR,    // header beat on the bus
        ST_PAY     // payload beats on the bus
    } state_t;

    state_t                     state;
    logic [CH_SEL_W-1:0]        rr_ptr;     // first channel to look at
    logic [CH_SEL_W-1:0]        cur_ch;     // channel being sent
    logic [CH_SEL_W-1:0]        next_ch;
    logic [CH_SEL_W-1:0]        pick_ch;
    logic                       pick_vld;
    logic [LEN_W-1:0]           rem;        // payload words not yet loaded
    logic [N_CH-1:0][SEQ_W-1:0] seq_cnt;
    msg_hdr_t                   hdr_next;
    msg_word_u                  tx_word;
    logic                       tx_vld;
    logic                       tx_last;
    logic                       start;
    logic                       load_pay;

    // ----------------------------------------------------------------------
    // round robin pick
    // ----------------------------------------------------------------------
    always_comb begin : rr_pick
        int idx;
        pick_vld = 1'b0;
        pick_ch  = rr_ptr;
        // walk backwards so the nearest channel after rr_ptr wins
        for (int k = N_CH - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % N_CH;
            if (msg_avail[idx]) begin
                pick_vld = 1'b1;
                pick_ch  = CH_SEL_W'(idx);
            end
        end
    end

    assign next_ch = (cur_ch == CH_SEL_W'(N_CH - 1)) ? '0 : cur_ch + 1'b1;

    // header for the picked channel
    always_comb begin
        hdr_next       = '0;
        hdr_next.ch_id = CH_ID_W'(pick_ch);
        hdr_next.seq   = seq_cnt[pick_ch];
        hdr_next.len   = head_len[pick_ch];
    end

    assign start    = (state == ST_IDLE) && pick_vld;
    // next payload word goes out when the current beat is taken
    assign load_pay = tx_ready && ((state == ST_HDR) || ((state == ST_PAY) && !tx_last));

    always_comb begin
        pop = '0;
        if (load_pay)
            pop[cur_ch] = 1'b1;   // one word per load
    end

    // ----------------------------------------------------------------------
    // control FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            rr_ptr  <= '0;
            cur_ch  <= '0;
            rem     <= '0;
            seq_cnt <= '0;
            tx_vld  <= 1'b0;
            tx_last <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pick_vld) begin
                        cur_ch  <= pick_ch;
                        rem     <= head_len[pick_ch];
                        tx_vld  <= 1'b1;
                        tx_last <= 1'b0;
                        state   <= ST_HDR;
                    end
                end
                ST_HDR: begin
                    if (tx_ready) begin
                        seq_cnt[cur_ch] <= seq_cnt[cur_ch] + 1'b1;   // wraps
                        state           <= ST_PAY;
                    end
                end
                ST_PAY: begin
                    if (tx_ready && tx_last) begin   // message done
                        tx_vld  <= 1'b0;
                        tx_last <= 1'b0;
                        rr_ptr  <= next_ch;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase

            if (load_pay) begin
                rem     <= rem - 1'b1;
                tx_last <= (rem == LEN_W'(1));
            end
        end
    end

    // beat word holds while tx_ready is low
    always_ff @(posedge clk) begin
        if (start)
            tx_word.hdr <= hdr_next;
        else if (load_pay)
            tx_word.raw <= head_word[cur_ch].data;
    end

    assign tx_msg = '{valid: tx_vld, data: tx_word.raw, last: tx_last};

    // held beat must not move before it is taken
    a_tx_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_msg.valid && !tx_ready) |=> $stable(tx_msg));

    // queued last flag agrees with the header length
    a_len_match: assert property (@(posedge clk) disable iff (!rst_n)
        load_pay |-> (head_word[cur_ch].last == (rem == LEN_W'(1))));

endmodule

//--- pp_link.f
common/pp_link_pkg.sv
hw/chan_fifo.sv
packer/msg_packer.sv
unpacker/msg_unpacker.sv
hw/pp_link_top.sv
dv/pp_link_checker.sv
dv/pp_link_tb.sv

//--- unpacker/msg_unpacker.sv
module msg_unpacker (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  pp_link_pkg::msg_beat_t                            rx_msg,
    output pp_link_pkg::chan_beat_t [pp_link_pkg::N_CH-1:0]   ch_out,
    output logic                                              msg_err,
    output logic                                              seq_err
);
    import pp_link_pkg::*;

    msg_word_u                  rx_word;   // same bits read two ways
    logic                       in_msg;    // header seen and payload open
    logic                       drop;      // bad channel so swallow payload
    logic [CH_SEL_W-1:0]        cur_ch;
    logic [CH_SEL_W-1:0]        hdr_ch;
    logic                       hdr_ok;
    logic [LEN_W-1:0]           cnt;       // payload words received
    logic [LEN_W-1:0]           cnt_next;
    logic [LEN_W-1:0]           exp_len;
    logic [N_CH-1:0][SEQ_W-1:0] exp_seq;
    logic [N_CH-1:0]            out_vld;
    logic [DATA_W-1:0]          out_data;  // only one channel active at a time
    logic                       out_last;

    assign rx_word  = msg_word_u'(rx_msg.data);
    assign hdr_ok   = rx_word.hdr.ch_id < CH_ID_W'(N_CH);
    assign hdr_ch   = CH_SEL_W'(rx_word.hdr.ch_id);
    assign cnt_next = cnt + 1'b1;

    // ----------------------------------------------------------------------
    // header decode and checks
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_msg  <= 1'b0;
            drop    <= 1'b0;
            cur_ch  <= '0;
            cnt     <= '0;
            exp_len <= '0;
            exp_seq <= '0;
            out_vld <= '0;
            msg_err <= 1'b0;
            seq_err <= 1'b0;
        end else begin
            out_vld <= '0;   // single cycle pulses
            msg_err <= 1'b0;
            seq_err <= 1'b0;
            if (rx_msg.valid) begin
                if (!in_msg) begin
                    in_msg  <= !rx_msg.last;   // header only msg closes at once
                    cnt     <= '0;
                    exp_len <= rx_word.hdr.len;
                    if (!hdr_ok) begin
                        drop    <= 1'b1;
                        msg_err <= 1'b1;
                    end else begin
                        drop   <= 1'b0;
                        cur_ch <= hdr_ch;
                        if (rx_word.hdr.seq != exp_seq[hdr_ch])
                            seq_err <= 1'b1;   // still delivered
                        exp_seq[hdr_ch] <= rx_word.hdr.seq + 1'b1;   // resync
                        if (rx_msg.last && (rx_word.hdr.len != '0))
                            msg_err <= 1'b1;
                    end
                end else begin
                    cnt <= cnt_next;
                    if (!drop)
                        out_vld[cur_ch] <= 1'b1;
                    if (rx_msg.last) begin
                        in_msg <= 1'b0;
                        if (!drop && (cnt_next != exp_len))
                            msg_err <= 1'b1;   // length mismatch
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // payload path
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rx_msg.valid && in_msg) begin
            out_data <= rx_word.raw;
            out_last <= rx_msg.last;
        end
    end

    always_comb begin
        for (int i = 0; i < N_CH; i++) begin
            ch_out[i].valid = out_vld[i];
            ch_out[i].data  = out_data;
            ch_out[i].last  = out_last;
        end
    end

endmodule
